// ==== src/udp_tx_pkg.sv ====
`default_nettype none

package udp_tx_pkg;

    localparam int MAX_PAYLOAD_BYTES = 256;
    localparam int FIFO_DEPTH        = 512;
    localparam int LEN_QUEUE_DEPTH   = 4;

    localparam int PREAMBLE_BYTES = 7;
    localparam int HEADER_BYTES   = 42;
    localparam int FCS_BYTES      = 4;
    localparam int GAP_BYTES      = 12;

    localparam logic [7:0]  PREAMBLE_BYTE  = 8'h55;
    localparam logic [7:0]  SFD_BYTE       = 8'hD5;
    localparam logic [7:0]  IP_TTL         = 8'd64;
    localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;
    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;

    typedef struct packed {
        logic [47:0] mac;
        logic [31:0] ip;
        logic [15:0] port;
    } endpoint_t;

    typedef logic [10:0] payload_len_t;

    // fields in wire order, msb byte leaves first
    typedef struct packed {
        logic [47:0] eth_dst;
        logic [47:0] eth_src;
        logic [15:0] ethertype;
        logic [7:0]  ver_ihl;
        logic [7:0]  tos;
        logic [15:0] total_len;
        logic [15:0] ident;
        logic [15:0] flags_frag;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] ip_csum;
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] udp_len;
        logic [15:0] udp_csum;
    } frame_header_t;

    typedef enum logic [2:0] {
        BEAT_PREAMBLE = 3'd0,
        BEAT_SFD      = 3'd1,
        BEAT_HEADER   = 3'd2,
        BEAT_PAYLOAD  = 3'd3,
        BEAT_FCS      = 3'd4
    } beat_kind_t;

    typedef struct packed {
        logic       valid;
        beat_kind_t kind;
        logic [7:0] data;
    } tx_beat_t;

endpackage

`default_nettype wire

// ==== src/udp_header_build.sv ====
`default_nettype none

module udp_header_build (
    input  udp_tx_pkg::endpoint_t     local_ep_i,
    input  udp_tx_pkg::endpoint_t     remote_ep_i,
    input  udp_tx_pkg::payload_len_t  len_i,
    output udp_tx_pkg::frame_header_t header_o
);

    import udp_tx_pkg::*;

    frame_header_t hdr_base;
    logic [19:0]   csum_sum;
    logic [16:0]   csum_fold1;
    logic [16:0]   csum_fold2;

    // everything except the ip checksum
    always_comb begin
        hdr_base            = '0;
        hdr_base.eth_dst    = remote_ep_i.mac;
        hdr_base.eth_src    = local_ep_i.mac;
        hdr_base.ethertype  = ETHERTYPE_IPV4;
        hdr_base.ver_ihl    = 8'h45;
        hdr_base.tos        = 8'h00;
        hdr_base.total_len  = 16'(len_i) + 16'd28;
        hdr_base.ident      = 16'h0000;
        hdr_base.flags_frag = 16'h0000;
        hdr_base.ttl        = IP_TTL;
        hdr_base.protocol   = IP_PROTO_UDP;
        hdr_base.ip_csum    = 16'h0000;
        hdr_base.src_ip     = local_ep_i.ip;
        hdr_base.dst_ip     = remote_ep_i.ip;
        hdr_base.src_port   = local_ep_i.port;
        hdr_base.dst_port   = remote_ep_i.port;
        hdr_base.udp_len    = 16'(len_i) + 16'd8;
        // udp checksum not computed
        hdr_base.udp_csum   = 16'h0000;
    end

    // ten ipv4 header words, checksum word still zero
    assign csum_sum = 20'({hdr_base.ver_ihl, hdr_base.tos})
                    + 20'(hdr_base.total_len)
                    + 20'(hdr_base.ident)
                    + 20'(hdr_base.flags_frag)
                    + 20'({hdr_base.ttl, hdr_base.protocol})
                    + 20'(hdr_base.ip_csum)
                    + 20'(hdr_base.src_ip[31:16])
                    + 20'(hdr_base.src_ip[15:0])
                    + 20'(hdr_base.dst_ip[31:16])
                    + 20'(hdr_base.dst_ip[15:0]);

    // end-around carry, twice covers the worst case
    assign csum_fold1 = 17'(csum_sum[15:0]) + 17'(csum_sum[19:16]);
    assign csum_fold2 = 17'(csum_fold1[15:0]) + 17'(csum_fold1[16]);

    always_comb begin
        header_o         = hdr_base;
        header_o.ip_csum = ~csum_fold2[15:0];
    end

endmodule

`default_nettype wire

// ==== src/payload_fifo.sv ====
`default_nettype none

module payload_fifo (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic [7:0]               s_tdata_i,
    input  logic                     s_tvalid_i,
    input  logic                     s_tlast_i,
    input  udp_tx_pkg::payload_len_t s_tlen_i,
    output logic                     s_tready_o,
    input  logic                     pop_i,
    output logic [7:0]               rd_data_o,
    input  logic                     pkt_done_i,
    output logic                     pkt_avail_o,
    output udp_tx_pkg::payload_len_t pkt_len_o
);

    import udp_tx_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);
    localparam int QW = $clog2(LEN_QUEUE_DEPTH);

    logic [7:0]         mem [FIFO_DEPTH];
    logic [AW-1:0]      wr_ptr;
    logic [AW-1:0]      rd_ptr;
    logic [AW:0]        count;
    logic [AW:0]        free_space;

    payload_len_t       lq_mem [LEN_QUEUE_DEPTH];
    logic [QW-1:0]      lq_wr;
    logic [QW-1:0]      lq_rd;
    logic [QW:0]        lq_cnt;
    logic               lq_full;

    logic               in_pkt;
    logic               first_beat;
    payload_len_t       cur_len;
    logic               push;
    logic               lq_push;

    assign first_beat = !in_pkt;
    assign free_space = (AW + 1)'(FIFO_DEPTH) - count;
    assign lq_full    = (lq_cnt == (QW + 1)'(LEN_QUEUE_DEPTH));

    // whole packet must fit before its first byte is taken
    assign s_tready_o = in_pkt || ((free_space >= (AW + 1)'(s_tlen_i)) && !lq_full);
    assign push       = s_tvalid_i && s_tready_o;
    assign lq_push    = push && s_tlast_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            in_pkt <= 1'b0;
            lq_wr  <= '0;
            lq_rd  <= '0;
            lq_cnt <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
                in_pkt <= !s_tlast_i;
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (AW + 1)'(push) - (AW + 1)'(pop_i);
            if (lq_push) begin
                lq_wr <= lq_wr + 1'b1;
            end
            if (pkt_done_i) begin
                lq_rd <= lq_rd + 1'b1;
            end
            lq_cnt <= lq_cnt + (QW + 1)'(lq_push) - (QW + 1)'(pkt_done_i);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr] <= s_tdata_i;
        end
        if (push && first_beat) begin
            cur_len <= s_tlen_i;
        end
        // single-beat packets queue their length straight from the sideband
        if (lq_push) begin
            lq_mem[lq_wr] <= first_beat ? s_tlen_i : cur_len;
        end
        if (pop_i) begin
            rd_data_o <= mem[rd_ptr];
        end
    end

    assign pkt_avail_o = (lq_cnt != '0);
    assign pkt_len_o   = lq_mem[lq_rd];

    a_no_push_full: assert property (@(posedge clk_i) disable iff (rst_i)
        push |-> (count < (AW + 1)'(FIFO_DEPTH)));
    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (rst_i)
        pop_i |-> (count != '0));
    a_done_needs_pkt: assert property (@(posedge clk_i) disable iff (rst_i)
        pkt_done_i |-> pkt_avail_o);
    a_len_legal: assert property (@(posedge clk_i) disable iff (rst_i)
        (push && first_beat) |-> (s_tlen_i != '0 && s_tlen_i <= MAX_PAYLOAD_BYTES));

endmodule

`default_nettype wire

// ==== src/frame_sequencer.sv ====
`default_nettype none

module frame_sequencer (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      pkt_avail_i,
    input  udp_tx_pkg::payload_len_t  pkt_len_i,
    input  udp_tx_pkg::frame_header_t header_i,
    output logic                      pop_o,
    input  logic [7:0]                rd_data_i,
    output logic                      pkt_done_o,
    output udp_tx_pkg::tx_beat_t      beat_o,
    output udp_tx_pkg::payload_len_t  hdr_len_o
);

    import udp_tx_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_SFD,
        ST_HEADER,
        ST_PAYLOAD,
        ST_FCS,
        ST_GAP
    } phase_t;

    phase_t                              state;
    logic [10:0]                         cnt;
    logic                                phase_last;
    payload_len_t                        len_q;
    logic [$bits(frame_header_t)-1:0]    hdr_sh;
    logic                                fcs_beat;

    always_comb begin
        case (state)
            ST_PREAMBLE: phase_last = (cnt == 11'(PREAMBLE_BYTES - 1));
            ST_SFD:      phase_last = 1'b1;
            ST_HEADER:   phase_last = (cnt == 11'(HEADER_BYTES - 1));
            ST_PAYLOAD:  phase_last = (cnt == len_q - 1'b1);
            ST_FCS:      phase_last = (cnt == 11'(FCS_BYTES - 1));
            ST_GAP:      phase_last = (cnt == 11'(GAP_BYTES - 1));
            default:     phase_last = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= ST_IDLE;
            cnt   <= '0;
        end else begin
            if (state == ST_IDLE) begin
                cnt <= '0;
                if (pkt_avail_i) begin
                    state <= ST_PREAMBLE;
                end
            end else if (phase_last) begin
                cnt <= '0;
                case (state)
                    ST_PREAMBLE: state <= ST_SFD;
                    ST_SFD:      state <= ST_HEADER;
                    ST_HEADER:   state <= ST_PAYLOAD;
                    ST_PAYLOAD:  state <= ST_FCS;
                    ST_FCS:      state <= ST_GAP;
                    default:     state <= ST_IDLE;
                endcase
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == ST_IDLE && pkt_avail_i) begin
            len_q <= pkt_len_i;
        end
        // header settles from len_q one cycle after leaving idle
        if (state == ST_PREAMBLE && cnt == '0) begin
            hdr_sh <= header_i;
        end else if (state == ST_HEADER) begin
            hdr_sh <= hdr_sh << 8;
        end
    end

    assign hdr_len_o = len_q;

    // fetch one byte ahead of each payload beat
    assign pop_o = (state == ST_HEADER && phase_last) ||
                   (state == ST_PAYLOAD && !phase_last);
    assign pkt_done_o = (state == ST_PAYLOAD) && phase_last;

    always_comb begin
        beat_o = '0;
        case (state)
            ST_PREAMBLE: begin
                beat_o.valid = 1'b1;
                beat_o.kind  = BEAT_PREAMBLE;
                beat_o.data  = PREAMBLE_BYTE;
            end
            ST_SFD: begin
                beat_o.valid = 1'b1;
                beat_o.kind  = BEAT_SFD;
                beat_o.data  = SFD_BYTE;
            end
            ST_HEADER: begin
                beat_o.valid = 1'b1;
                beat_o.kind  = BEAT_HEADER;
                beat_o.data  = hdr_sh[$bits(frame_header_t)-1 -: 8];
            end
            ST_PAYLOAD: begin
                beat_o.valid = 1'b1;
                beat_o.kind  = BEAT_PAYLOAD;
                beat_o.data  = rd_data_i;
            end
            ST_FCS: begin
                // data filled in by the transmit stage
                beat_o.valid = 1'b1;
                beat_o.kind  = BEAT_FCS;
            end
            default: beat_o = '0;
        endcase
    end

    assign fcs_beat = beat_o.valid && (beat_o.kind == BEAT_FCS);

    a_fcs_four_beats: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(fcs_beat) |-> fcs_beat [*FCS_BYTES] ##1 !fcs_beat);

endmodule

`default_nettype wire

// ==== src/gmii_tx_stage.sv ====
`default_nettype none

module gmii_tx_stage (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  udp_tx_pkg::tx_beat_t beat_i,
    output logic                 tx_en_o,
    output logic [7:0]           tx_d_o
);

    import udp_tx_pkg::*;

    logic [31:0] crc_q;
    logic        is_fcs;
    logic [7:0]  out_byte;

    // lsb-first crc-32, reflected form of 0x04C11DB7
    function automatic logic [31:0] crc32_byte(input logic [31:0] crc, input logic [7:0] d);
        logic [31:0] c;
        c = crc ^ {24'h000000, d};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ 32'hEDB88320;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    assign is_fcs   = beat_i.valid && (beat_i.kind == BEAT_FCS);
    assign out_byte = is_fcs ? ~crc_q[7:0] : beat_i.data;

    always_ff @(posedge clk_i) begin
        if (beat_i.valid) begin
            case (beat_i.kind)
                BEAT_SFD: begin
                    crc_q <= '1;
                end
                BEAT_HEADER, BEAT_PAYLOAD: begin
                    crc_q <= crc32_byte(crc_q, beat_i.data);
                end
                BEAT_FCS: begin
                    // next fcs byte moves down to the bottom
                    crc_q <= {8'hFF, crc_q[31:8]};
                end
                default: begin
                    crc_q <= crc_q;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            tx_en_o <= 1'b0;
        end else begin
            tx_en_o <= beat_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        tx_d_o <= out_byte;
    end

endmodule

`default_nettype wire

// ==== src/udp_tx_top.sv ====
`default_nettype none

module udp_tx_top (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  udp_tx_pkg::endpoint_t    local_ep_i,
    input  udp_tx_pkg::endpoint_t    remote_ep_i,
    input  logic [7:0]               s_tdata_i,
    input  logic                     s_tvalid_i,
    input  logic                     s_tlast_i,
    input  udp_tx_pkg::payload_len_t s_tlen_i,
    output logic                     s_tready_o,
    output logic                     tx_en_o,
    output logic [7:0]               tx_d_o
);

    import udp_tx_pkg::*;

    logic          pop;
    logic [7:0]    rd_data;
    logic          pkt_done;
    logic          pkt_avail;
    payload_len_t  pkt_len;
    payload_len_t  hdr_len;
    frame_header_t header;
    tx_beat_t      beat;

    payload_fifo u_fifo (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .s_tdata_i   (s_tdata_i),
        .s_tvalid_i  (s_tvalid_i),
        .s_tlast_i   (s_tlast_i),
        .s_tlen_i    (s_tlen_i),
        .s_tready_o  (s_tready_o),
        .pop_i       (pop),
        .rd_data_o   (rd_data),
        .pkt_done_i  (pkt_done),
        .pkt_avail_o (pkt_avail),
        .pkt_len_o   (pkt_len)
    );

    udp_header_build u_hdr (
        .local_ep_i  (local_ep_i),
        .remote_ep_i (remote_ep_i),
        .len_i       (hdr_len),
        .header_o    (header)
    );

    frame_sequencer u_seq (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .pkt_avail_i (pkt_avail),
        .pkt_len_i   (pkt_len),
        .header_i    (header),
        .pop_o       (pop),
        .rd_data_i   (rd_data),
        .pkt_done_o  (pkt_done),
        .beat_o      (beat),
        .hdr_len_o   (hdr_len)
    );

    gmii_tx_stage u_gmii (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .beat_i  (beat),
        .tx_en_o (tx_en_o),
        .tx_d_o  (tx_d_o)
    );

endmodule

`default_nettype wire

// ==== dv/udp_tx_tb.sv ====
`default_nettype none

module udp_tx_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import udp_tx_pkg::*;

    localparam int MAX_PKTS = 16;

    localparam endpoint_t EP_A = {48'h02_1A_2B_3C_4D_01, 32'hC0A8_0A01, 16'd5001};
    localparam endpoint_t EP_B = {48'h3C_97_0E_55_AA_F2, 32'hC0A8_0A64, 16'd8080};
    localparam endpoint_t EP_C = {48'hF0_DE_F1_12_34_56, 32'h0A00_00FE, 16'hFFFE};
    localparam endpoint_t EP_D = {48'h00_11_22_33_44_55, 32'hAC10_FF07, 16'd53};

    logic         clk_i = 1'b0;
    logic         rst_i;
    endpoint_t    local_ep_i;
    endpoint_t    remote_ep_i;
    logic [7:0]   s_tdata_i;
    logic         s_tvalid_i;
    logic         s_tlast_i;
    payload_len_t s_tlen_i;
    wire          s_tready_o;
    wire          tx_en_o;
    wire  [7:0]   tx_d_o;

    // packet table, payload bytes stored flat
    int           n_pkts = 0;
    int           tab_len [MAX_PKTS];
    int           tab_gap [MAX_PKTS];
    bit           tab_burst [MAX_PKTS];
    int           tab_off [MAX_PKTS];
    endpoint_t    tab_lep [MAX_PKTS];
    endpoint_t    tab_rep [MAX_PKTS];
    logic [7:0]   pay_mem [4096];
    int           pay_fill = 0;
    logic [31:0]  rng = 32'd10;

    int           mis_errs = 0;
    int           other_errs = 0;
    int           stall_cycles = 0;
    int           frames_seen = 0;
    int           ep_sel = 0;
    bit           timed_out = 1'b0;
    logic [7:0]   rx_q [$];
    logic [7:0]   exp_bytes [$];

    always #4 clk_i = ~clk_i;

    // endpoints change only in the gap after a frame
    assign local_ep_i  = tab_lep[ep_sel];
    assign remote_ep_i = tab_rep[ep_sel];

    udp_tx_top dut0 (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .local_ep_i  (local_ep_i),
        .remote_ep_i (remote_ep_i),
        .s_tdata_i   (s_tdata_i),
        .s_tvalid_i  (s_tvalid_i),
        .s_tlast_i   (s_tlast_i),
        .s_tlen_i    (s_tlen_i),
        .s_tready_o  (s_tready_o),
        .tx_en_o     (tx_en_o),
        .tx_d_o      (tx_d_o)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // bitwise reflected crc-32, one byte lsb first
    function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic [7:0] d);
        logic [31:0] c;
        logic        fb;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            fb = c[0] ^ d[i];
            c  = {1'b0, c[31:1]};
            if (fb) begin
                c = c ^ 32'hEDB88320;
            end
        end
        return c;
    endfunction

    function automatic logic [15:0] fold_ones(input logic [31:0] sum);
        logic [31:0] s;
        s = sum;
        while (s[31:16] != 16'h0000) begin
            s = 32'(s[15:0]) + 32'(s[31:16]);
        end
        return s[15:0];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            mis_errs++;
        end
    endtask

    task automatic add_pkt(input int len, input int gap, input bit burst,
                           input endpoint_t lep, input endpoint_t rep);
        tab_len[n_pkts]   = len;
        tab_gap[n_pkts]   = gap;
        tab_burst[n_pkts] = burst;
        tab_off[n_pkts]   = pay_fill;
        tab_lep[n_pkts]   = lep;
        tab_rep[n_pkts]   = rep;
        for (int b = 0; b < len; b++) begin
            rng = xorshift32(rng);
            pay_mem[pay_fill] = rng[7:0];
            pay_fill++;
        end
        n_pkts++;
    endtask

    task automatic load_table();
        add_pkt(1, 5, 1'b0, EP_A, EP_B);
        add_pkt(18, 3, 1'b0, EP_A, EP_C);
        add_pkt(256, 10, 1'b0, EP_D, EP_B);
        // back to back, more than the fifo holds
        for (int i = 0; i < 6; i++) begin
            add_pkt(200, 0, 1'b1, EP_A, (i % 2 == 0) ? EP_B : EP_C);
        end
        add_pkt(64, 2, 1'b0, EP_D, EP_C);
        add_pkt(3, 0, 1'b0, EP_C, EP_A);
    endtask

    task automatic build_frame(input int k);
        logic [7:0]  hdr [42];
        logic [15:0] tl;
        logic [15:0] ul;
        logic [31:0] sum;
        logic [31:0] crc;
        endpoint_t   lep;
        endpoint_t   rep;
        lep = tab_lep[k];
        rep = tab_rep[k];
        tl  = 16'(tab_len[k] + 28);
        ul  = 16'(tab_len[k] + 8);
        for (int i = 0; i < 6; i++) begin
            hdr[i]     = rep.mac[47 - 8 * i -: 8];
            hdr[6 + i] = lep.mac[47 - 8 * i -: 8];
        end
        hdr[12] = 8'h08;
        hdr[13] = 8'h00;
        hdr[14] = 8'h45;
        hdr[15] = 8'h00;
        hdr[16] = tl[15:8];
        hdr[17] = tl[7:0];
        for (int i = 18; i < 22; i++) begin
            hdr[i] = 8'h00;
        end
        hdr[22] = 8'd64;
        hdr[23] = 8'd17;
        hdr[24] = 8'h00;
        hdr[25] = 8'h00;
        for (int i = 0; i < 4; i++) begin
            hdr[26 + i] = lep.ip[31 - 8 * i -: 8];
            hdr[30 + i] = rep.ip[31 - 8 * i -: 8];
        end
        hdr[34] = lep.port[15:8];
        hdr[35] = lep.port[7:0];
        hdr[36] = rep.port[15:8];
        hdr[37] = rep.port[7:0];
        hdr[38] = ul[15:8];
        hdr[39] = ul[7:0];
        hdr[40] = 8'h00;
        hdr[41] = 8'h00;
        sum = 32'h0;
        for (int i = 14; i < 34; i += 2) begin
            sum = sum + 32'({hdr[i], hdr[i + 1]});
        end
        {hdr[24], hdr[25]} = ~fold_ones(sum);

        exp_bytes.delete();
        for (int i = 0; i < 7; i++) begin
            exp_bytes.push_back(8'h55);
        end
        exp_bytes.push_back(8'hD5);
        crc = 32'hFFFF_FFFF;
        for (int i = 0; i < 42; i++) begin
            exp_bytes.push_back(hdr[i]);
            crc = crc_step(crc, hdr[i]);
        end
        for (int b = 0; b < tab_len[k]; b++) begin
            exp_bytes.push_back(pay_mem[tab_off[k] + b]);
            crc = crc_step(crc, pay_mem[tab_off[k] + b]);
        end
        crc = ~crc;
        for (int i = 0; i < 4; i++) begin
            exp_bytes.push_back(crc[8 * i +: 8]);
        end
    endtask

    task automatic check_frame(input int k);
        int          n;
        logic [31:0] sum;
        build_frame(k);
        check_value($sformatf("frame%0d burst_len", k), 32'(rx_q.size()),
                    32'(exp_bytes.size()));
        n = (rx_q.size() < exp_bytes.size()) ? rx_q.size() : exp_bytes.size();
        for (int i = 0; i < n; i++) begin
            check_value($sformatf("frame%0d tx_d_o[%0d]", k, i), 32'(rx_q[i]),
                        32'(exp_bytes[i]));
        end
        // received ipv4 header must sum to all ones
        if (rx_q.size() >= 50) begin
            sum = 32'h0;
            for (int i = 22; i < 42; i += 2) begin
                sum = sum + 32'({rx_q[i], rx_q[i + 1]});
            end
            check_value($sformatf("frame%0d ip_hdr_sum", k), 32'(fold_ones(sum)), 32'hFFFF);
        end
    endtask

    task automatic drive_packets();
        int idle;
        for (int k = 0; k < n_pkts; k++) begin
            for (int b = 0; b < tab_len[k]; b++) begin
                if (!tab_burst[k]) begin
                    rng = xorshift32(rng);
                    if (rng[2:0] == 3'd0) begin
                        idle = int'(rng[4:3]) + 1;
                        s_tvalid_i = 1'b0;
                        repeat (idle) @(negedge clk_i);
                    end
                end
                s_tdata_i  = pay_mem[tab_off[k] + b];
                s_tvalid_i = 1'b1;
                s_tlast_i  = (b == tab_len[k] - 1);
                s_tlen_i   = 11'(tab_len[k]);
                #1;
                // rest of an admitted packet is never held off
                if (b > 0) begin
                    check_value("s_tready_o", 32'(s_tready_o), 32'h1);
                end
                while (!s_tready_o) begin
                    if (tab_burst[k]) begin
                        stall_cycles++;
                    end
                    @(negedge clk_i);
                    #1;
                end
                @(negedge clk_i);
            end
            s_tvalid_i = 1'b0;
            s_tlast_i  = 1'b0;
            repeat (tab_gap[k]) @(negedge clk_i);
        end
    endtask

    // gmii monitor, one sample per falling edge
    initial begin
        bit in_frame;
        int low_cnt;
        in_frame = 1'b0;
        low_cnt  = 0;
        forever begin
            @(negedge clk_i);
            if (rst_i) begin
                check_value("tx_en_o in reset", 32'(tx_en_o), 32'h0);
            end else if (tx_en_o) begin
                if (!in_frame) begin
                    if (frames_seen > 0 && low_cnt < 12) begin
                        $display("only %0d idle cycles before frame %0d", low_cnt, frames_seen);
                        other_errs++;
                    end
                    if (frames_seen >= n_pkts) begin
                        $display("unexpected extra frame after the last table entry");
                        other_errs++;
                    end
                end
                in_frame = 1'b1;
                rx_q.push_back(tx_d_o);
            end else begin
                if (in_frame) begin
                    if (frames_seen < n_pkts) begin
                        check_frame(frames_seen);
                    end
                    frames_seen++;
                    rx_q.delete();
                    low_cnt = 0;
                    if (frames_seen < n_pkts) begin
                        ep_sel = frames_seen;
                    end
                end
                in_frame = 1'b0;
                low_cnt++;
            end
        end
    end

    initial begin
        int limit_ns;
        rst_i      = 1'b1;
        s_tdata_i  = 8'h00;
        s_tvalid_i = 1'b0;
        s_tlast_i  = 1'b0;
        s_tlen_i   = '0;
        load_table();
        limit_ns = 0;
        for (int k = 0; k < n_pkts; k++) begin
            limit_ns += (tab_len[k] + 70) * 4 * 8;
        end
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        // empty fifo takes input straight away
        check_value("s_tready_o after reset", 32'(s_tready_o), 32'h1);
        rst_i = 1'b0;
        fork
            begin
                drive_packets();
                wait (frames_seen == n_pkts);
                // room for a duplicate frame to show up
                repeat (100) @(negedge clk_i);
            end
            begin
                #(limit_ns);
                timed_out = 1'b1;
            end
        join_any
        if (timed_out) begin
            $display("timeout while waiting for frame %0d of %0d", frames_seen, n_pkts);
            other_errs++;
        end
        if (stall_cycles == 0) begin
            $display("input ready never dropped during the back to back packets");
            other_errs++;
        end
        $display("errors: %0d mismatches, %0d other failures", mis_errs, other_errs);
        if (mis_errs == 0 && other_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
src/udp_tx_pkg.sv
src/udp_header_build.sv
src/payload_fifo.sv
src/frame_sequencer.sv
src/gmii_tx_stage.sv
src/udp_tx_top.sv
dv/udp_tx_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with verilator, run, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module udp_tx_tb \
    --Mdir obj_dir -o udp_tx_sim -f vlog.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/udp_tx_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q '^>>> PASS$'; then
    exit 0
fi
exit 1
